// File: Makefile
# Verilator flow for the lsu testbench

VERILATOR  ?= verilator
TOP        ?= lsu_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
RUN_ARGS   ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+include
src/lsu_pkg.sv
src/lsu_addr_gen.sv
src/lsu_req_ctrl.sv
src/lsu_ctx_reg.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
verification/lsu_assert.sv
verification/lsu_tb.sv

// File: include/lsu_config.svh
// lsu configuration macros for bus and word geometry
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

//////////////////////////////
// memory bus geometry
//////////////////////////////

`define LSU_ADDR_W 32 // byte address width
`define LSU_DATA_W 32 // one memory word
`define LSU_BE_W   4  // one enable per byte lane

//////////////////////////////
// word layout
//////////////////////////////

// low address bits that select the byte lane inside a word
`define LSU_OFS_W  2

`endif

// File: src/lsu_addr_gen.sv
// lsu address generator with split detection, byte enables and store data rotation
`include "lsu_config.svh"

module lsu_addr_gen
(
  input  lsu_pkg::lsu_req_t req_i,        // access from ex
  output lsu_pkg::mem_req_t mem_o,        // request fields toward memory
  output logic              misaligned_o  // a second part is needed
);

  logic [`LSU_ADDR_W-1:0] addr;
  logic [`LSU_OFS_W-1:0]  ofs;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata_rot;

  //////////////////////////////
  // effective address
  //////////////////////////////

  assign addr = req_i.useincr ? (req_i.operand_a + req_i.operand_b) : req_i.operand_a;
  assign ofs  = addr[`LSU_OFS_W-1:0]; // byte lane of the first byte

  // word off lane 0, or half word starting in the top lane
  always_comb
  begin
    misaligned_o = 1'b0;
    if (!req_i.second)
    begin
      if (req_i.dtype == lsu_pkg::DT_WORD && ofs != 2'd0)
        misaligned_o = 1'b1;
      if (req_i.dtype == lsu_pkg::DT_HALF && ofs == 2'd3)
        misaligned_o = 1'b1;
    end
  end

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb
  begin
    case (req_i.dtype)
      lsu_pkg::DT_WORD:
      begin
        if (!req_i.second)
          be = 4'b1111 << ofs;        // lanes from the offset up
        else
          be = ~(4'b1111 << ofs);     // lanes below the offset
      end
      lsu_pkg::DT_HALF:
      begin
        if (!req_i.second)
          be = 4'b0011 << ofs;        // top lane only at offset 3
        else
          be = 4'b0001;               // spilled byte lands in lane 0
      end
      default: be = 4'b0001 << ofs;   // single byte
    endcase
  end

  //////////////////////////////
  // store data rotation
  //////////////////////////////

  // byte 0 of the register goes to the lane at the offset
  always_comb
  begin
    case (ofs)
      2'd0: wdata_rot = req_i.wdata;
      2'd1: wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'd2: wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // both parts carry the same rotated word, the enables pick the lanes
  assign mem_o.addr  = addr;
  assign mem_o.we    = req_i.we;
  assign mem_o.be    = be;
  assign mem_o.wdata = wdata_rot;

endmodule

// File: src/lsu_ctx_reg.sv
// lsu context register, holds the accepted access attributes for the response phase
`include "lsu_config.svh"

module lsu_ctx_reg
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  capture_i,  // request granted
  input  lsu_pkg::lsu_req_t     req_i,      // access from ex
  input  logic [`LSU_OFS_W-1:0] offset_i,   // low bits of the effective address

  output lsu_pkg::lsu_ctx_t     ctx_o       // steers the aligner
);

  lsu_pkg::lsu_ctx_t ctx_q;

  //////////////////////////////
  // capture on grant
  //////////////////////////////

  // loaded while the previous response may still be in flight,
  // rvalid of that response arrives in this same grant cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctx_q.dtype    <= lsu_pkg::DT_WORD;
      ctx_q.offset   <= '0;
      ctx_q.sign_ext <= 1'b0;
      ctx_q.we       <= 1'b0;
      ctx_q.second   <= 1'b0;
    end
    else if (capture_i)
    begin
      ctx_q.dtype    <= req_i.dtype;
      ctx_q.offset   <= offset_i;
      ctx_q.sign_ext <= req_i.sign_ext;
      ctx_q.we       <= req_i.we;      // stores leave the read data alone
      ctx_q.second   <= req_i.second;
    end
  end

  assign ctx_o = ctx_q;

endmodule

// File: src/lsu_pkg.sv
// lsu package with the access size encoding and the request and context structs
package lsu_pkg;

  // access size as encoded by the decoder, byte has two codes
  typedef enum logic [1:0] {
    DT_WORD     = 2'b00,
    DT_HALF     = 2'b01,
    DT_BYTE     = 2'b10,
    DT_BYTE_ALT = 2'b11
  } data_type_e;

  // access presented by ex, 102 bits
  typedef struct packed {
    logic        we;        // store when set
    data_type_e  dtype;
    logic        sign_ext;  // loads only
    logic        useincr;   // address is a + b
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] wdata;     // unrotated store data
    logic        second;    // second part of a split access
  } lsu_req_t;

  // request toward data memory, 69 bits
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;     // already rotated to the byte lanes
  } mem_req_t;

  // what the response phase needs to know, 7 bits
  typedef struct packed {
    data_type_e  dtype;
    logic [1:0]  offset;    // byte lane of the access
    logic        sign_ext;
    logic        we;
    logic        second;
  } lsu_ctx_t;

endpackage

// File: src/lsu_rdata_align.sv
// lsu read aligner, picks and extends load data and joins the two words of a split load
`include "lsu_config.svh"

module lsu_rdata_align
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  lsu_pkg::lsu_ctx_t      ctx_i,         // context of the answered access
  input  logic                   mem_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] mem_rdata_i,
  input  logic                   misaligned_i,  // answered access needs a second part

  output logic [`LSU_DATA_W-1:0] rdata_o        // load result toward wb
);

  logic [`LSU_DATA_W-1:0] rdata_q;   // first word of a split load, else last result
  logic [`LSU_DATA_W-1:0] word_al;
  logic [`LSU_DATA_W-1:0] half_al;
  logic [`LSU_DATA_W-1:0] byte_al;
  logic [`LSU_DATA_W-1:0] aligned;
  logic [15:0]            half_raw;
  logic [7:0]             byte_raw;

  //////////////////////////////
  // word assembly
  //////////////////////////////

  // upper bytes were saved from the first word, lower ones arrive now
  always_comb
  begin
    case (ctx_i.offset)
      2'd0: word_al = mem_rdata_i;
      2'd1: word_al = {mem_rdata_i[7:0], rdata_q[31:8]};
      2'd2: word_al = {mem_rdata_i[15:0], rdata_q[31:16]};
      default: word_al = {mem_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  //////////////////////////////
  // half word and byte pick
  //////////////////////////////

  always_comb
  begin
    case (ctx_i.offset)
      2'd0: half_raw = mem_rdata_i[15:0];
      2'd1: half_raw = mem_rdata_i[23:8];
      2'd2: half_raw = mem_rdata_i[31:16];
      default: half_raw = {mem_rdata_i[7:0], rdata_q[31:24]}; // low byte from first word
    endcase
  end

  assign byte_raw = mem_rdata_i[8*ctx_i.offset +: 8];

  // sign or zero fill of the upper bits
  assign half_al = ctx_i.sign_ext ? {{(`LSU_DATA_W-16){half_raw[15]}}, half_raw}
                                  : {{(`LSU_DATA_W-16){1'b0}}, half_raw};
  assign byte_al = ctx_i.sign_ext ? {{(`LSU_DATA_W-8){byte_raw[7]}}, byte_raw}
                                  : {{(`LSU_DATA_W-8){1'b0}}, byte_raw};

  always_comb
  begin
    case (ctx_i.dtype)
      lsu_pkg::DT_WORD: aligned = word_al;
      lsu_pkg::DT_HALF: aligned = half_al;
      default:          aligned = byte_al;
    endcase
  end

  //////////////////////////////
  // held read data
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (mem_rvalid_i && !ctx_i.we)
    begin
      if (misaligned_i && !ctx_i.second)
        rdata_q <= mem_rdata_i;  // raw first word, joined on the second response
      else
        rdata_q <= aligned;      // final result held for wb
    end
  end

  // live result in the rvalid cycle, held copy afterwards
  assign rdata_o = mem_rvalid_i ? aligned : rdata_q;

endmodule

// File: src/lsu_req_ctrl.sv
// lsu request controller, drives req toward memory and the ex and wb ready signals
module lsu_req_ctrl
(
  input  logic clk,
  input  logic rst_n,

  input  logic req_valid_i,   // ex has an access
  input  logic mem_gnt_i,     // memory took the request
  input  logic mem_rvalid_i,  // response of the outstanding access

  output logic mem_req_o,     // request toward memory
  output logic capture_o,     // access accepted this cycle
  output logic ready_ex_o,    // ex may move on
  output logic ready_wb_o     // wb has its data
);

  typedef enum logic {
    IDLE,
    WAIT_RVALID
  } state_e;

  state_e state_q;
  state_e state_d;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb
  begin
    state_d    = state_q;
    mem_req_o  = 1'b0;
    ready_ex_o = !req_valid_i;  // a pending access stalls ex
    ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        mem_req_o = req_valid_i;
        if (req_valid_i && mem_gnt_i)
        begin
          ready_ex_o = 1'b1;  // accepted in the grant cycle
          state_d    = WAIT_RVALID;
        end
      end

      WAIT_RVALID:
      begin
        ready_wb_o = mem_rvalid_i;
        if (mem_rvalid_i)
        begin
          // old access done, next one may go out in the same cycle
          mem_req_o = req_valid_i;
          if (req_valid_i && mem_gnt_i)
            ready_ex_o = 1'b1;  // stay and wait for the new response
          else
            state_d = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // only one place where a request counts as taken
  assign capture_o = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

endmodule

// File: src/lsu_top.sv
// lsu top level, connects address generation, request control, context and read alignment
`include "lsu_config.svh"

module lsu_top
(
  input  logic                   clk,
  input  logic                   rst_n,

  // ex side
  input  logic                   req_valid_i,
  input  lsu_pkg::lsu_req_t      req_i,
  output logic                   misaligned_o,  // first part of a split access
  output logic                   ready_ex_o,
  output logic                   ready_wb_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,       // load result

  // data memory side
  output logic                   mem_req_o,
  output lsu_pkg::mem_req_t      mem_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] mem_rdata_i
);

  logic              capture;     // request and grant
  lsu_pkg::lsu_ctx_t ctx;         // registered access context
  logic              first_part;  // answered access was the first of two

  lsu_addr_gen i_addr_gen
  (
    .req_i        (req_i),
    .mem_o        (mem_o),
    .misaligned_o (misaligned_o)
  );

  lsu_req_ctrl i_req_ctrl
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_req_o    (mem_req_o),
    .capture_o    (capture),
    .ready_ex_o   (ready_ex_o),
    .ready_wb_o   (ready_wb_o)
  );

  lsu_ctx_reg i_ctx_reg
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .capture_i (capture),
    .req_i     (req_i),
    .offset_i  (mem_o.addr[`LSU_OFS_W-1:0]),
    .ctx_o     (ctx)
  );

  // split flag rebuilt from registered size, lane and second bit
  assign first_part = !ctx.second &&
                      ((ctx.dtype == lsu_pkg::DT_WORD && ctx.offset != 2'd0) ||
                       (ctx.dtype == lsu_pkg::DT_HALF && ctx.offset == 2'd3));

  lsu_rdata_align i_rdata_align
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctx_i        (ctx),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .misaligned_i (first_part),
    .rdata_o      (rdata_o)
  );

endmodule

// File: verification/lsu_assert.sv
// lsu protocol checker, bound onto the top level
module lsu_assert
(
  input logic              clk,
  input logic              rst_n,
  input lsu_pkg::lsu_req_t req_i,
  input logic              mem_req_o,
  input lsu_pkg::mem_req_t mem_o,
  input logic              mem_gnt_i,
  input logic              mem_rvalid_i,
  input logic              ready_ex_o,
  input logic              ready_wb_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // read by the testbench at the end
  logic        outst_q;       // an access waits for rvalid
  logic [3:0]  be_first_q;    // enables of the last accepted first part

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      outst_q <= 1'b0;
    else if (mem_req_o && mem_gnt_i)
      outst_q <= 1'b1;
    else if (mem_rvalid_i)
      outst_q <= 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      be_first_q <= '0;
    else if (mem_req_o && mem_gnt_i && !req_i.second)
      be_first_q <= mem_o.be;
  end

  // lanes hit by the bytes of the access that fall into this part's word
  function automatic logic [3:0] be_table(logic [1:0] dt, logic second, logic [1:0] ofs);
    logic [3:0] be;
    int         n;
    int         pos;
    n  = (dt == 2'd0) ? 4 : (dt == 2'd1) ? 2 : 1;
    be = '0;
    for (int k = 0; k < n; k++)
    begin
      pos = int'(ofs) + k;        // byte position counted from lane 0 of the first word
      if (!second && pos < 4)
        be[pos] = 1'b1;
      if (second && pos >= 4)
        be[pos - 4] = 1'b1;       // spilled into the next word
    end
    return be;
  endfunction

  a_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    (!mem_req_o && !ready_ex_o) |-> !mem_gnt_i)
    else begin fail_cnt++; $error("req and ready_ex low together with grant"); end

  a_no_x: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |-> !$isunknown(mem_o))
    else begin fail_cnt++; $error("unknown bits on memory request"); end

  a_wb_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (outst_q && !mem_rvalid_i) |-> !ready_wb_o)
    else begin fail_cnt++; $error("ready_wb high while access outstanding"); end

  a_reset: assert property (@(posedge clk) $rose(rst_n) |-> (ready_ex_o && ready_wb_o))
    else begin fail_cnt++; $error("ready signals low after reset"); end

  a_be: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |-> (mem_o.be == be_table(req_i.dtype, req_i.second, mem_o.addr[1:0])))
    else begin fail_cnt++; $error("byte enables do not match the table"); end

  // second part must not touch a lane of the first part
  a_be_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_o && mem_gnt_i && req_i.second) |-> ((mem_o.be & be_first_q) == 4'b0000))
    else begin fail_cnt++; $error("second part enables overlap the first part"); end

  // stalled request keeps ex stalled and the request unchanged
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_o && !mem_gnt_i) |-> !ready_ex_o ##1 $stable(mem_o))
    else begin fail_cnt++; $error("request changed or ex released without grant"); end

endmodule

bind lsu_top lsu_assert i_lsu_assert (.*);

// File: verification/lsu_tb.sv
// lsu testbench with ex driver, data memory model and data checks
`include "lsu_config.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 6;
  localparam int CLK_PERIOD = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid_i;
  lsu_pkg::lsu_req_t      req_i;
  logic                   misaligned_o;
  logic                   ready_ex_o;
  logic                   ready_wb_o;
  logic [`LSU_DATA_W-1:0] rdata_o;
  logic                   mem_req_o;
  lsu_pkg::mem_req_t      mem_o;
  logic                   mem_gnt_i;
  logic                   mem_rvalid_i;
  logic [`LSU_DATA_W-1:0] mem_rdata_i;

  int          seed = 40539;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] mem [64];       // memory model words
  logic [7:0]  ref_b [256];    // expected byte image
  logic [31:0] resp_q [$];     // rdata_o seen in each rvalid cycle
  logic        pend = 1'b0;
  int          rv_cnt = 0;
  int          gnt_wait = 0;
  logic [31:0] rd_word;
  logic        hold_gnt = 1'b0;  // withhold grant
  logic        fast = 1'b0;      // grant without delay

  lsu_top i_lsu_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////// 
  // memory model
  //////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (mem_rvalid_i)
      begin
        resp_q.push_back(rdata_o);
        pend = 1'b0;
      end
      if (mem_req_o && mem_gnt_i)
      begin
        for (int b = 0; b < 4; b++)
          if (mem_o.we && mem_o.be[b])
            mem[mem_o.addr[7:2]][8*b +: 8] = mem_o.wdata[8*b +: 8];
        rd_word  = mem[mem_o.addr[7:2]];
        pend     = 1'b1;
        rv_cnt   = 1 + int'($unsigned($random(seed)) % 3);
        gnt_wait = fast ? 0 : int'($unsigned($random(seed)) % 3);
      end
      else if (mem_req_o && gnt_wait > 0)
        gnt_wait--;
      if (pend)
        rv_cnt--;
    end
    #1;
    mem_rvalid_i = pend && rv_cnt == 0;
    mem_rdata_i  = mem_rvalid_i ? rd_word : $random(seed);
    mem_gnt_i    = !hold_gnt && gnt_wait == 0 && (!pend || mem_rvalid_i);
  end

  function automatic logic [31:0] fill_word(int i);
    return (32'h9e3779b9 * (i + 1)) ^ {i[7:0], 24'h5a5a5a};
  endfunction

  // little endian bytes from the image, then sign or zero fill
  function automatic logic [31:0] expect_load(logic [31:0] addr, logic [1:0] dt, logic sx);
    logic [31:0] v;
    int          n;
    n = (dt == 2'd0) ? 4 : (dt == 2'd1) ? 2 : 1;
    v = '0;
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = ref_b[8'(addr[7:0] + k)];
    if (sx && n == 2)
      v = {{16{v[15]}}, v[15:0]};
    if (sx && n == 1)
      v = {{24{v[7]}}, v[7:0]};
    return v;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////
  // ex side driver
  //////////////////////////////

  task automatic drive_part(logic we, logic [1:0] dt, logic sx, logic [31:0] addr,
                            logic [31:0] wd, logic second);
    logic [31:0] b;
    b = $unsigned($random(seed)) % 64;
    req_i.we        = we;
    req_i.dtype     = lsu_pkg::data_type_e'(dt);
    req_i.sign_ext  = sx;
    req_i.useincr   = b[0];                     // odd offset means a + b
    req_i.operand_a = b[0] ? addr - b : addr;
    req_i.operand_b = b[0] ? b : $random(seed);
    req_i.wdata     = wd;
    req_i.second    = second;
    req_valid_i     = 1'b1;
  endtask

  task automatic wait_accept(output logic mis);
    logic acc;
    do
    begin
      @(posedge clk);
      acc = mem_req_o && mem_gnt_i;
      mis = misaligned_o;
    end
    while (!acc);
    #1;
  endtask

  task automatic wait_resp(int n);
    while (resp_q.size() < n)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // one access, split in two parts when it crosses a word
  task automatic run_access(string name, logic we, logic [1:0] dt, logic sx,
                            logic [31:0] addr, logic [31:0] wd, output logic [31:0] res);
    logic split;
    logic mis;
    split = (dt == 2'd0 && addr[1:0] != 2'd0) || (dt == 2'd1 && addr[1:0] == 2'd3);
    drive_part(we, dt, sx, addr, wd, 1'b0);
    wait_accept(mis);
    check_val({name, " misaligned"}, 32'(split), 32'(mis));
    if (split)
    begin
      drive_part(we, dt, sx, addr + 32'd4, wd, 1'b1);
      wait_accept(mis);
    end
    req_valid_i = 1'b0;
    wait_resp(split ? 2 : 1);
    if (split)
      void'(resp_q.pop_front());  // raw first word
    res = resp_q.pop_front();
    if (we)
      for (int k = 0; k < ((dt == 2'd0) ? 4 : (dt == 2'd1) ? 2 : 1); k++)
        ref_b[8'(addr[7:0] + k)] = wd[8*k +: 8];
  endtask

  // memory words touched by an access against the byte image
  task automatic check_mem(string name, logic [31:0] addr);
    logic [31:0] w;
    logic [5:0]  idx;
    for (int j = 0; j < 2; j++)
    begin
      idx = addr[7:2] + 6'(j);
      w   = {ref_b[{idx, 2'd3}], ref_b[{idx, 2'd2}], ref_b[{idx, 2'd1}], ref_b[{idx, 2'd0}]};
      check_val(name, w, mem[idx]);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_aligned(logic we);
    logic [31:0] a;
    logic [31:0] wd;
    logic [31:0] res;
    for (int o = 0; o < 4; o++)
      for (int dt = 0; dt < 3; dt++)
        for (int sx = 0; sx < 2; sx++)
        begin
          if ((dt == 0 && o != 0) || (dt == 1 && o == 3))
            continue;
          a  = 32'((we ? 96 : 32) + 16 * o + o);
          wd = $random(seed);
          if (we)
          begin
            run_access("aligned_store", 1'b1, 2'(dt), 1'b0, a, wd, res);
            check_mem("aligned_store mem", a);
          end
          run_access("aligned_load", 1'b0, 2'(dt), sx[0], a, 32'd0, res);
          check_val("aligned_load", expect_load(a, 2'(dt), sx[0]), res);
        end
  endtask

  task automatic test_misaligned;
    logic [31:0] a;
    logic [31:0] res;
    for (int o = 1; o < 5; o++)
    begin
      a = 32'(160 + 12 * o + (o == 4 ? 3 : o));  // fourth pass is a half word at 3
      run_access("split_store", 1'b1, (o == 4) ? 2'd1 : 2'd0, 1'b0, a, $random(seed), res);
      check_mem("split_store mem", a);
      for (int sx = 0; sx < 2; sx++)
      begin
        run_access("split_load", 1'b0, (o == 4) ? 2'd1 : 2'd0, sx[0], a, 32'd0, res);
        check_val("split_load", expect_load(a, (o == 4) ? 2'd1 : 2'd0, sx[0]), res);
      end
    end
  endtask

  task automatic test_back_to_back;
    logic mis;
    fast = 1'b1;
    drive_part(1'b0, 2'd0, 1'b0, 32'h10, 32'd0, 1'b0);
    wait_accept(mis);
    drive_part(1'b0, 2'd1, 1'b1, 32'h16, 32'd0, 1'b0);  // goes out in the rvalid cycle
    wait_accept(mis);
    req_valid_i = 1'b0;
    wait_resp(2);
    check_val("b2b first", expect_load(32'h10, 2'd0, 1'b0), resp_q.pop_front());
    check_val("b2b second", expect_load(32'h16, 2'd1, 1'b1), resp_q.pop_front());
    repeat (3) @(posedge clk);
    check_val("b2b hold", expect_load(32'h16, 2'd1, 1'b1), rdata_o);
    #1;
    fast = 1'b0;
  endtask

  // random mix for the protocol assertions, data still checked
  task automatic test_random_mix;
    logic [31:0] a;
    logic [31:0] res;
    logic [1:0]  dt;
    logic        we;
    for (int i = 0; i < 24; i++)
    begin
      a  = $unsigned($random(seed)) % 200;
      dt = 2'($unsigned($random(seed)) % 4);
      we = 1'($random(seed));
      run_access("random_mix", we, dt, a[5], a, $random(seed), res);
      if (!we)
        check_val("random_mix", expect_load(a, dt, a[5]), res);
    end
  endtask

  task automatic test_back_pressure;
    logic        mis;
    logic [31:0] res;
    hold_gnt = 1'b1;
    @(posedge clk);
    #1;
    drive_part(1'b0, 2'd0, 1'b0, 32'h48, 32'd0, 1'b0);
    repeat (5)
    begin
      @(posedge clk);
      check_val("back_pressure ready_ex", 32'd0, 32'(ready_ex_o));
    end
    hold_gnt = 1'b0;  // memory sees it at its next drive
    wait_accept(mis);
    req_valid_i = 1'b0;
    wait_resp(1);
    res = resp_q.pop_front();
    check_val("back_pressure data", expect_load(32'h48, 2'd0, 1'b0), res);
  endtask

  task automatic report(string name, int e0);
    $display("test %-16s %s", name, (errors == e0) ? "ok" : "with errors");
  endtask

  initial
  begin
    int e0;
    int afail;
    logic [31:0] w;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    for (int i = 0; i < 64; i++)
    begin
      w      = fill_word(i);
      mem[i] = w;
      for (int k = 0; k < 4; k++)
        ref_b[4*i + k] = w[8*k +: 8];
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    e0 = errors; test_aligned(1'b0);    report("aligned_loads", e0);
    e0 = errors; test_aligned(1'b1);    report("aligned_stores", e0);
    e0 = errors; test_misaligned();     report("misaligned", e0);
    e0 = errors; test_back_to_back();   report("back_to_back", e0);
    e0 = errors; test_random_mix();     report("protocol_mix", e0);
    e0 = errors; test_back_pressure();  report("back_pressure", e0);
    afail = int'(i_lsu_top.i_lsu_assert.fail_cnt);
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afail);
    if (errors == 0 && afail == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog, 200 cycles per test
  initial
  begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("sim failed");
    $finish;
  end

endmodule
